//--- ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int XLEN = 32;
    localparam int DIV_STEPS = 32;
    localparam int STEP_W = $clog2(DIV_STEPS + 1);

    // divider fsm encoding
    localparam logic [1:0] DIV_IDLE = 2'd0;
    localparam logic [1:0] DIV_RUN = 2'd1;
    localparam logic [1:0] DIV_FINISH = 2'd2;

    typedef enum logic [1:0] {
        CLS_ALU    = 2'd0,
        CLS_BRANCH = 2'd1,
        CLS_DIV    = 2'd2,
        CLS_NOP    = 2'd3
    } class_e;

    typedef enum logic [1:0] {
        SRC1_RF   = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2
    } src1_e;

    typedef enum logic [1:0] {
        SRC2_RF     = 2'd0,
        SRC2_IMM    = 2'd1,
        SRC2_CNT_LO = 2'd2,
        SRC2_CNT_HI = 2'd3
    } src2_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_SLTU   = 4'd3,
        ALU_AND    = 4'd4,
        ALU_OR     = 4'd5,
        ALU_XOR    = 4'd6,
        ALU_NOR    = 4'd7,
        ALU_SLL    = 4'd8,
        ALU_SRL    = 4'd9,
        ALU_SRA    = 4'd10,
        ALU_PASS_B = 4'd11
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_EQ     = 4'd0,
        BR_NE     = 4'd1,
        BR_LT     = 4'd2,
        BR_GE     = 4'd3,
        BR_LTU    = 4'd4,
        BR_GEU    = 4'd5,
        BR_ALWAYS = 4'd6
    } br_cond_e;

    // same four bits, read by alu ops or by branch conditions
    typedef union packed {
        alu_op_e  alu;
        br_cond_e br;
    } func_u;

    // class is a keyword, hence op_class
    typedef struct packed {
        class_e op_class;
        src1_e  src1;
        src2_e  src2;
        func_u  func;
        logic   sign;
        logic   jirl;
    } uop_t;

endpackage

`default_nettype wire

//--- ex_bypass_if.sv
`timescale 1ns/100ps
`default_nettype none

interface ex_bypass_if;

    logic [1:0][4:0]  ex2_rd;
    logic [1:0][31:0] ex2_data;
    logic [1:0]       ex2_valid;
    logic [1:0][4:0]  wb_rd;
    logic [1:0][31:0] wb_data;
    logic [1:0]       wb_valid;

    modport producer (
        output ex2_rd, ex2_data, ex2_valid,
        output wb_rd, wb_data, wb_valid
    );

    modport consumer (
        input ex2_rd, ex2_data, ex2_valid,
        input wb_rd, wb_data, wb_valid
    );

endinterface

`default_nettype wire

//--- ex_bypass.sv
`timescale 1ns/100ps
`default_nettype none

module ex_bypass (
    input  logic [4:0]          rj_i,
    input  logic [4:0]          rk_i,
    input  logic [31:0]         rj_data_i,
    input  logic [31:0]         rk_data_i,
    ex_bypass_if.consumer       byp,
    output logic [31:0]         rj_data_o,
    output logic [31:0]         rk_data_o,
    output logic                stall_o
);

    logic rj_stall;
    logic rk_stall;

    // youngest slot first: ex2[1], ex2[0], wb[1], wb[0]
    function automatic void resolve(
        input  logic [4:0]  idx,
        input  logic [31:0] rf_data,
        output logic [31:0] data,
        output logic        stall
    );
        data = rf_data;
        stall = 1'b0;
        if (idx == 5'd0) begin
            data = rf_data;
        end else if (byp.ex2_rd[1] == idx) begin
            data = byp.ex2_data[1];
            stall = !byp.ex2_valid[1];
        end else if (byp.ex2_rd[0] == idx) begin
            data = byp.ex2_data[0];
            stall = !byp.ex2_valid[0];
        end else if (byp.wb_rd[1] == idx) begin
            data = byp.wb_data[1];
            stall = !byp.wb_valid[1];
        end else if (byp.wb_rd[0] == idx) begin
            data = byp.wb_data[0];
            stall = !byp.wb_valid[0];
        end
    endfunction

    always_comb begin
        resolve(rj_i, rj_data_i, rj_data_o, rj_stall);
    end

    always_comb begin
        resolve(rk_i, rk_data_i, rk_data_o, rk_stall);
    end

    assign stall_o = rj_stall | rk_stall;

endmodule

`default_nettype wire

//--- ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
    input  ex_pkg::uop_t                uop_i,
    input  logic [ex_pkg::XLEN-1:0]     pc_i,
    input  logic [ex_pkg::XLEN-1:0]     imm_i,
    input  logic [ex_pkg::XLEN-1:0]     rj_i,
    input  logic [ex_pkg::XLEN-1:0]     rk_i,
    input  logic [63:0]                 cnt_i,
    output logic [ex_pkg::XLEN-1:0]     result_o
);

    logic [ex_pkg::XLEN-1:0] op_a;
    logic [ex_pkg::XLEN-1:0] op_b;
    logic [ex_pkg::XLEN-1:0] alu_y;
    logic [4:0]              shamt;

    always_comb begin
        case (uop_i.src1)
            ex_pkg::SRC1_RF: op_a = rj_i;
            ex_pkg::SRC1_PC: op_a = pc_i;
            default:         op_a = '0;
        endcase
    end

    // counter halves feed the rdcntv reads
    always_comb begin
        case (uop_i.src2)
            ex_pkg::SRC2_RF:     op_b = rk_i;
            ex_pkg::SRC2_IMM:    op_b = imm_i;
            ex_pkg::SRC2_CNT_LO: op_b = cnt_i[31:0];
            default:             op_b = cnt_i[63:32];
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (uop_i.func.alu)
            ex_pkg::ALU_ADD:  alu_y = op_a + op_b;
            ex_pkg::ALU_SUB:  alu_y = op_a - op_b;
            ex_pkg::ALU_SLT:  alu_y = {{(ex_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ex_pkg::ALU_SLTU: alu_y = {{(ex_pkg::XLEN-1){1'b0}}, op_a < op_b};
            ex_pkg::ALU_AND:  alu_y = op_a & op_b;
            ex_pkg::ALU_OR:   alu_y = op_a | op_b;
            ex_pkg::ALU_XOR:  alu_y = op_a ^ op_b;
            ex_pkg::ALU_NOR:  alu_y = ~(op_a | op_b);
            ex_pkg::ALU_SLL:  alu_y = op_a << shamt;
            ex_pkg::ALU_SRL:  alu_y = op_a >> shamt;
            ex_pkg::ALU_SRA:  alu_y = $signed(op_a) >>> shamt;
            default:          alu_y = op_b;
        endcase
    end

    // branches write the link value
    always_comb begin
        case (uop_i.op_class)
            ex_pkg::CLS_BRANCH: result_o = pc_i + 32'd4;
            ex_pkg::CLS_NOP:    result_o = '0;
            default:            result_o = alu_y;
        endcase
    end

endmodule

`default_nettype wire

//--- ex_branch.sv
`timescale 1ns/100ps
`default_nettype none

module ex_branch (
    input  ex_pkg::uop_t                uop_i,
    input  logic [ex_pkg::XLEN-1:0]     pc_i,
    input  logic [ex_pkg::XLEN-1:0]     imm_i,
    input  logic [ex_pkg::XLEN-1:0]     rj_i,
    input  logic [ex_pkg::XLEN-1:0]     rk_i,
    input  logic                        predict_taken_i,
    input  logic [ex_pkg::XLEN-1:0]     predict_pc_i,
    output logic                        flush_o,
    output logic                        dir_fail_o,
    output logic                        addr_fail_o,
    output logic                        taken_o,
    output logic [ex_pkg::XLEN-1:0]     target_o
);

    logic                    is_br;
    logic                    cond;
    logic [ex_pkg::XLEN-1:0] target;

    assign is_br = (uop_i.op_class == ex_pkg::CLS_BRANCH);

    always_comb begin
        case (uop_i.func.br)
            ex_pkg::BR_EQ:     cond = (rj_i == rk_i);
            ex_pkg::BR_NE:     cond = (rj_i != rk_i);
            ex_pkg::BR_LT:     cond = ($signed(rj_i) < $signed(rk_i));
            ex_pkg::BR_GE:     cond = ($signed(rj_i) >= $signed(rk_i));
            ex_pkg::BR_LTU:    cond = (rj_i < rk_i);
            ex_pkg::BR_GEU:    cond = (rj_i >= rk_i);
            ex_pkg::BR_ALWAYS: cond = 1'b1;
            default:           cond = 1'b0;
        endcase
    end

    // jirl jumps relative to rj
    assign target = (uop_i.jirl ? rj_i : pc_i) + imm_i;

    assign taken_o = is_br & cond;
    assign target_o = is_br ? target : '0;
    assign dir_fail_o = is_br & (taken_o != predict_taken_i);
    assign addr_fail_o = taken_o & predict_taken_i & (target != predict_pc_i);
    assign flush_o = dir_fail_o | addr_fail_o;

endmodule

`default_nettype wire

//--- ex_div_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ex_div_ctrl (
    input  logic aclk,
    input  logic aresetn,
    input  logic req_i,
    input  logic flush_i,
    input  logic last_i,
    output logic start_o,
    output logic busy_o,
    output logic done_o,
    output logic stall_o
);

    logic [1:0] state_q;
    logic       start_q;

    // start leaves one cycle after acceptance, lane 0 is held by stall meanwhile
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= ex_pkg::DIV_IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                ex_pkg::DIV_IDLE: begin
                    if (req_i && !flush_i) begin
                        state_q <= ex_pkg::DIV_RUN;
                        start_q <= 1'b1;
                    end
                end
                ex_pkg::DIV_RUN: begin
                    if (last_i) begin
                        state_q <= ex_pkg::DIV_FINISH;
                    end
                end
                default: state_q <= ex_pkg::DIV_IDLE;
            endcase
        end
    end

    assign start_o = start_q;
    assign busy_o = (state_q != ex_pkg::DIV_IDLE);
    assign done_o = (state_q == ex_pkg::DIV_FINISH);
    assign stall_o = busy_o | req_i;

endmodule

`default_nettype wire

//--- ex_div_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module ex_div_datapath (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        start_i,
    input  logic                        step_i,
    input  logic                        sign_i,
    input  logic [ex_pkg::XLEN-1:0]     dividend_i,
    input  logic [ex_pkg::XLEN-1:0]     divisor_i,
    output logic [ex_pkg::XLEN-1:0]     quotient_o,
    output logic [ex_pkg::XLEN-1:0]     remainder_o
);

    localparam int W = ex_pkg::XLEN;

    logic [W-1:0] dvs_q;
    logic [W-1:0] dvd_q;
    logic [W-1:0] rem_q;
    logic [W-1:0] quo_q;
    logic         q_neg_q;
    logic         r_neg_q;
    logic         zero_q;
    logic         dvd_neg;
    logic         dvs_neg;
    logic [W:0]   shifted;
    logic [W+1:0] diff;

    assign dvd_neg = sign_i & dividend_i[W-1];
    assign dvs_neg = sign_i & divisor_i[W-1];

    // one restoring step, top bit of diff is the borrow
    assign shifted = {rem_q, quo_q[W-1]};
    assign diff = {1'b0, shifted} - {2'b00, dvs_q};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            q_neg_q <= 1'b0;
            r_neg_q <= 1'b0;
            zero_q <= 1'b0;
        end else if (start_i) begin
            q_neg_q <= dvd_neg ^ dvs_neg;
            r_neg_q <= dvd_neg;
            zero_q <= (divisor_i == '0);
        end
    end

    always_ff @(posedge aclk) begin
        if (start_i) begin
            dvd_q <= dividend_i;
            dvs_q <= dvs_neg ? -divisor_i : divisor_i;
            quo_q <= dvd_neg ? -dividend_i : dividend_i;
            rem_q <= '0;
        end else if (step_i) begin
            rem_q <= diff[W+1] ? shifted[W-1:0] : diff[W-1:0];
            quo_q <= {quo_q[W-2:0], ~diff[W+1]};
        end
    end

    assign quotient_o = zero_q ? '1 : (q_neg_q ? -quo_q : quo_q);
    assign remainder_o = zero_q ? dvd_q : (r_neg_q ? -rem_q : rem_q);

endmodule

`default_nettype wire

//--- ex_timer.sv
`timescale 1ns/100ps
`default_nettype none

module ex_timer (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        start_i,
    output logic [63:0] counter_o,
    output logic        step_o,
    output logic        last_o
);

    logic [63:0]               stable_q;
    logic [ex_pkg::STEP_W-1:0] steps_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stable_q <= '0;
        end else begin
            stable_q <= stable_q + 64'd1;
        end
    end

    // steps left in the current divide
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            steps_q <= '0;
        end else if (start_i) begin
            steps_q <= ex_pkg::STEP_W'(ex_pkg::DIV_STEPS);
        end else if (step_o) begin
            steps_q <= steps_q - ex_pkg::STEP_W'(1);
        end
    end

    assign counter_o = stable_q;
    assign step_o = (steps_q != '0);
    assign last_o = (steps_q == ex_pkg::STEP_W'(1));

endmodule

`default_nettype wire

//--- ex1_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex1_stage (
    input  logic         aclk,
    input  logic         aresetn,
    input  logic [31:0]  pc0_i,
    input  logic [31:0]  pc1_i,
    input  ex_pkg::uop_t uop0_i,
    input  ex_pkg::uop_t uop1_i,
    input  logic [31:0]  imm0_i,
    input  logic [31:0]  imm1_i,
    input  logic [4:0]   rj0_i,
    input  logic [4:0]   rk0_i,
    input  logic [4:0]   rj1_i,
    input  logic [4:0]   rk1_i,
    input  logic [31:0]  rj0_data_i,
    input  logic [31:0]  rk0_data_i,
    input  logic [31:0]  rj1_data_i,
    input  logic [31:0]  rk1_data_i,
    input  logic [4:0]   ex2_rd0_i,
    input  logic [4:0]   ex2_rd1_i,
    input  logic [31:0]  ex2_data0_i,
    input  logic [31:0]  ex2_data1_i,
    input  logic         ex2_valid0_i,
    input  logic         ex2_valid1_i,
    input  logic [4:0]   wb_rd0_i,
    input  logic [4:0]   wb_rd1_i,
    input  logic [31:0]  wb_data0_i,
    input  logic [31:0]  wb_data1_i,
    input  logic         wb_valid0_i,
    input  logic         wb_valid1_i,
    input  logic         predict_taken_i,
    input  logic [31:0]  predict_pc_i,
    output logic [31:0]  result0_o,
    output logic [31:0]  result1_o,
    output logic         forward_stall_o,
    output logic         flush_o,
    output logic         dir_fail_o,
    output logic         addr_fail_o,
    output logic         taken_o,
    output logic [31:0]  target_o,
    output logic [31:0]  quotient_o,
    output logic [31:0]  remainder_o,
    output logic         div_stall_o,
    output logic         div_done_o,
    output logic [63:0]  counter_o
);

    logic [31:0] rj0_fwd;
    logic [31:0] rk0_fwd;
    logic [31:0] rj1_fwd;
    logic [31:0] rk1_fwd;
    logic        stall0;
    logic        stall1;
    logic        div_req;
    logic        div_start;
    logic        div_step;
    logic        div_last;

    ex_bypass_if byp_if ();

    assign byp_if.ex2_rd[0] = ex2_rd0_i;
    assign byp_if.ex2_rd[1] = ex2_rd1_i;
    assign byp_if.ex2_data[0] = ex2_data0_i;
    assign byp_if.ex2_data[1] = ex2_data1_i;
    assign byp_if.ex2_valid = {ex2_valid1_i, ex2_valid0_i};
    assign byp_if.wb_rd[0] = wb_rd0_i;
    assign byp_if.wb_rd[1] = wb_rd1_i;
    assign byp_if.wb_data[0] = wb_data0_i;
    assign byp_if.wb_data[1] = wb_data1_i;
    assign byp_if.wb_valid = {wb_valid1_i, wb_valid0_i};

    assign forward_stall_o = stall0 | stall1;
    // divider only takes lane 0 once its operands are resolved
    assign div_req = (uop0_i.op_class == ex_pkg::CLS_DIV) & ~stall0;

    ex_bypass u_byp0 (
        .rj_i(rj0_i), .rk_i(rk0_i), .rj_data_i(rj0_data_i), .rk_data_i(rk0_data_i),
        .byp(byp_if), .rj_data_o(rj0_fwd), .rk_data_o(rk0_fwd), .stall_o(stall0)
    );

    ex_bypass u_byp1 (
        .rj_i(rj1_i), .rk_i(rk1_i), .rj_data_i(rj1_data_i), .rk_data_i(rk1_data_i),
        .byp(byp_if), .rj_data_o(rj1_fwd), .rk_data_o(rk1_fwd), .stall_o(stall1)
    );

    ex_alu u_alu0 (
        .uop_i(uop0_i), .pc_i(pc0_i), .imm_i(imm0_i), .rj_i(rj0_fwd), .rk_i(rk0_fwd),
        .cnt_i(counter_o), .result_o(result0_o)
    );

    ex_alu u_alu1 (
        .uop_i(uop1_i), .pc_i(pc1_i), .imm_i(imm1_i), .rj_i(rj1_fwd), .rk_i(rk1_fwd),
        .cnt_i(counter_o), .result_o(result1_o)
    );

    ex_branch u_branch (
        .uop_i(uop0_i), .pc_i(pc0_i), .imm_i(imm0_i), .rj_i(rj0_fwd), .rk_i(rk0_fwd),
        .predict_taken_i(predict_taken_i), .predict_pc_i(predict_pc_i),
        .flush_o(flush_o), .dir_fail_o(dir_fail_o), .addr_fail_o(addr_fail_o),
        .taken_o(taken_o), .target_o(target_o)
    );

    ex_timer u_timer (
        .aclk(aclk), .aresetn(aresetn), .start_i(div_start),
        .counter_o(counter_o), .step_o(div_step), .last_o(div_last)
    );

    ex_div_ctrl u_div_ctrl (
        .aclk(aclk), .aresetn(aresetn), .req_i(div_req), .flush_i(flush_o),
        .last_i(div_last), .start_o(div_start), .busy_o(), .done_o(div_done_o),
        .stall_o(div_stall_o)
    );

    ex_div_datapath u_div_dp (
        .aclk(aclk), .aresetn(aresetn), .start_i(div_start), .step_i(div_step),
        .sign_i(uop0_i.sign), .dividend_i(rj0_fwd), .divisor_i(rk0_fwd),
        .quotient_o(quotient_o), .remainder_o(remainder_o)
    );

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic aclk_o,
    output logic aresetn_o
);

    initial begin
        aclk_o = 1'b0;
        forever #4 aclk_o = ~aclk_o;
    end

    // reset held over four rising edges, released just after the last
    initial begin
        aresetn_o = 1'b0;
        repeat (4) @(posedge aclk_o);
        #1;
        aresetn_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_ex1_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ex1_stage;

    logic         aclk;
    logic         aresetn;
    logic [31:0]  pc0, pc1, imm0, imm1;
    logic [4:0]   rj0, rk0, rj1, rk1;
    logic [31:0]  rj0_d, rk0_d, rj1_d, rk1_d;
    ex_pkg::uop_t uop0;
    ex_pkg::uop_t uop1;
    logic [4:0]   ex2_rd [2];
    logic [31:0]  ex2_data [2];
    logic         ex2_valid [2];
    logic [4:0]   wb_rd [2];
    logic [31:0]  wb_data [2];
    logic         wb_valid [2];
    logic         ptaken;
    logic [31:0]  ppc;

    logic [31:0]  result0, result1, target, quotient, remainder;
    logic         fwd_stall, flush, dir_fail, addr_fail, taken, div_stall, div_done;
    logic [63:0]  counter;

    logic [63:0]  edges;
    int           errors;
    int           timeouts;
    int           wait_n;

    tb_clkgen u_clkgen (.aclk_o(aclk), .aresetn_o(aresetn));

    ex1_stage dut_i (
        .aclk(aclk), .aresetn(aresetn),
        .pc0_i(pc0), .pc1_i(pc1), .uop0_i(uop0), .uop1_i(uop1),
        .imm0_i(imm0), .imm1_i(imm1),
        .rj0_i(rj0), .rk0_i(rk0), .rj1_i(rj1), .rk1_i(rk1),
        .rj0_data_i(rj0_d), .rk0_data_i(rk0_d), .rj1_data_i(rj1_d), .rk1_data_i(rk1_d),
        .ex2_rd0_i(ex2_rd[0]), .ex2_rd1_i(ex2_rd[1]),
        .ex2_data0_i(ex2_data[0]), .ex2_data1_i(ex2_data[1]),
        .ex2_valid0_i(ex2_valid[0]), .ex2_valid1_i(ex2_valid[1]),
        .wb_rd0_i(wb_rd[0]), .wb_rd1_i(wb_rd[1]),
        .wb_data0_i(wb_data[0]), .wb_data1_i(wb_data[1]),
        .wb_valid0_i(wb_valid[0]), .wb_valid1_i(wb_valid[1]),
        .predict_taken_i(ptaken), .predict_pc_i(ppc),
        .result0_o(result0), .result1_o(result1), .forward_stall_o(fwd_stall),
        .flush_o(flush), .dir_fail_o(dir_fail), .addr_fail_o(addr_fail),
        .taken_o(taken), .target_o(target),
        .quotient_o(quotient), .remainder_o(remainder),
        .div_stall_o(div_stall), .div_done_o(div_done), .counter_o(counter)
    );

    // rising edges since reset release
    always @(posedge aclk) begin
        if (!aresetn) begin
            edges <= '0;
        end else begin
            edges <= edges + 64'd1;
        end
    end

    task automatic report_value(input string name, input logic [63:0] expv,
                                input logic [63:0] actv);
        errors++;
        $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, expv, actv);
    endtask

    function automatic void bypass_model(input logic [4:0] idx, input logic [31:0] rf,
                                         output logic [31:0] data, output logic stall);
        logic [4:0]  rd_y [4];
        logic [31:0] dat_y [4];
        logic        vld_y [4];
        logic        found;
        // youngest first
        rd_y = '{ex2_rd[1], ex2_rd[0], wb_rd[1], wb_rd[0]};
        dat_y = '{ex2_data[1], ex2_data[0], wb_data[1], wb_data[0]};
        vld_y = '{ex2_valid[1], ex2_valid[0], wb_valid[1], wb_valid[0]};
        data = rf;
        stall = 1'b0;
        found = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (!found && idx != 5'd0 && rd_y[i] == idx) begin
                found = 1'b1;
                data = dat_y[i];
                stall = !vld_y[i];
            end
        end
    endfunction

    function automatic logic [31:0] alu_model(input ex_pkg::uop_t u, input logic [31:0] pc,
                                              input logic [31:0] imm, input logic [31:0] rj,
                                              input logic [31:0] rk, input logic [63:0] cnt);
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] ext;
        logic [4:0]  sh;
        if (u.op_class == ex_pkg::CLS_BRANCH) begin
            return pc + 32'd4;
        end
        if (u.op_class == ex_pkg::CLS_NOP) begin
            return 32'd0;
        end
        a = (u.src1 == ex_pkg::SRC1_RF) ? rj : (u.src1 == ex_pkg::SRC1_PC) ? pc : 32'd0;
        case (u.src2)
            ex_pkg::SRC2_RF:     b = rk;
            ex_pkg::SRC2_IMM:    b = imm;
            ex_pkg::SRC2_CNT_LO: b = cnt[31:0];
            default:             b = cnt[63:32];
        endcase
        sh = b[4:0];
        ext = {{32{a[31]}}, a} >> sh;
        case (u.func.alu)
            ex_pkg::ALU_ADD:  return a + b;
            ex_pkg::ALU_SUB:  return a - b;
            ex_pkg::ALU_SLT:  return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            ex_pkg::ALU_SLTU: return {31'd0, a < b};
            ex_pkg::ALU_AND:  return a & b;
            ex_pkg::ALU_OR:   return a | b;
            ex_pkg::ALU_XOR:  return a ^ b;
            ex_pkg::ALU_NOR:  return ~(a | b);
            ex_pkg::ALU_SLL:  return a << sh;
            ex_pkg::ALU_SRL:  return a >> sh;
            ex_pkg::ALU_SRA:  return ext[31:0];
            default:          return b;
        endcase
    endfunction

    function automatic void branch_model(input ex_pkg::uop_t u, input logic [31:0] pc,
                                         input logic [31:0] imm, input logic [31:0] rj,
                                         input logic [31:0] rk, output logic tk,
                                         output logic [31:0] tgt, output logic df,
                                         output logic af);
        logic is_br;
        logic lt;
        logic cond;
        is_br = (u.op_class == ex_pkg::CLS_BRANCH);
        lt = (rj[31] != rk[31]) ? rj[31] : (rj < rk);
        case (u.func.br)
            ex_pkg::BR_EQ:     cond = (rj == rk);
            ex_pkg::BR_NE:     cond = (rj != rk);
            ex_pkg::BR_LT:     cond = lt;
            ex_pkg::BR_GE:     cond = !lt;
            ex_pkg::BR_LTU:    cond = (rj < rk);
            ex_pkg::BR_GEU:    cond = !(rj < rk);
            ex_pkg::BR_ALWAYS: cond = 1'b1;
            default:           cond = 1'b0;
        endcase
        tk = is_br && cond;
        tgt = is_br ? ((u.jirl ? rj : pc) + imm) : 32'd0;
        df = is_br && (tk != ptaken);
        af = tk && ptaken && (tgt != ppc);
    endfunction

    function automatic void divide_model(input logic sg, input logic [31:0] a,
                                         input logic [31:0] b, output logic [31:0] q,
                                         output logic [31:0] r);
        logic        a_neg;
        logic        b_neg;
        logic [31:0] ma;
        logic [31:0] mb;
        a_neg = sg && a[31];
        b_neg = sg && b[31];
        ma = a_neg ? (~a + 32'd1) : a;
        mb = b_neg ? (~b + 32'd1) : b;
        if (b == 32'd0) begin
            q = '1;
            r = a;
        end else begin
            q = ma / mb;
            r = ma % mb;
            if (a_neg != b_neg) begin
                q = ~q + 32'd1;
            end
            if (a_neg) begin
                r = ~r + 32'd1;
            end
        end
    endfunction

    function automatic ex_pkg::uop_t random_alu_uop();
        ex_pkg::uop_t u;
        u.op_class = ($urandom % 8 == 0) ? ex_pkg::CLS_NOP : ex_pkg::CLS_ALU;
        u.src1 = ex_pkg::src1_e'(2'($urandom % 3));
        u.src2 = ex_pkg::src2_e'(2'($urandom % 4));
        u.func.alu = ex_pkg::alu_op_e'(4'($urandom % 12));
        u.sign = 1'($urandom);
        u.jirl = 1'($urandom);
        return u;
    endfunction

    // mode 0 bypass, 1 alu, 2 branch
    task automatic drive_random(input int mode);
        logic [31:0] a0;
        logic        s0;
        @(posedge aclk);
        #1;
        for (int i = 0; i < 2; i++) begin
            ex2_rd[i] = 5'($urandom % 4);
            ex2_data[i] = $urandom;
            ex2_valid[i] = ($urandom % 4) != 0;
            wb_rd[i] = 5'($urandom % 4);
            wb_data[i] = $urandom;
            wb_valid[i] = ($urandom % 4) != 0;
        end
        rj0 = 5'($urandom % 4);
        rk0 = 5'($urandom % 4);
        rj1 = 5'($urandom % 4);
        rk1 = 5'($urandom % 4);
        rj0_d = $urandom;
        rk0_d = $urandom;
        rj1_d = $urandom;
        rk1_d = $urandom;
        pc0 = $urandom & 32'hffff_fffc;
        pc1 = $urandom & 32'hffff_fffc;
        imm0 = $urandom;
        imm1 = $urandom;
        ptaken = 1'($urandom);
        ppc = $urandom & 32'hffff_fffc;
        uop0 = random_alu_uop();
        uop1 = random_alu_uop();
        if (mode == 0) begin
            // add of both registers exposes both bypassed operands
            uop0 = '0;
            uop0.op_class = ex_pkg::CLS_ALU;
            uop0.func.alu = ex_pkg::ALU_ADD;
            uop1 = uop0;
        end else if (mode == 2) begin
            uop0.op_class = ex_pkg::CLS_BRANCH;
            uop0.func.br = ex_pkg::br_cond_e'(4'($urandom % 7));
            bypass_model(rj0, rj0_d, a0, s0);
            if ($urandom % 2 == 0) begin
                ppc = (uop0.jirl ? a0 : pc0) + imm0;
            end
        end
    endtask

    task automatic check_comb();
        logic [31:0] a0, b0, a1, b1, exp0, exp1, tgt;
        logic        s0a, s0b, s1a, s1b, tk, df, af;
        bypass_model(rj0, rj0_d, a0, s0a);
        bypass_model(rk0, rk0_d, b0, s0b);
        bypass_model(rj1, rj1_d, a1, s1a);
        bypass_model(rk1, rk1_d, b1, s1b);
        exp0 = alu_model(uop0, pc0, imm0, a0, b0, edges);
        exp1 = alu_model(uop1, pc1, imm1, a1, b1, edges);
        branch_model(uop0, pc0, imm0, a0, b0, tk, tgt, df, af);
        if (result0 !== exp0) report_value("result0_o", 64'(exp0), 64'(result0));
        if (result1 !== exp1) report_value("result1_o", 64'(exp1), 64'(result1));
        if (fwd_stall !== (s0a | s0b | s1a | s1b)) begin
            report_value("forward_stall_o", 64'(s0a | s0b | s1a | s1b), 64'(fwd_stall));
        end
        if (taken !== tk) report_value("taken_o", 64'(tk), 64'(taken));
        if (target !== tgt) report_value("target_o", 64'(tgt), 64'(target));
        if (dir_fail !== df) report_value("dir_fail_o", 64'(df), 64'(dir_fail));
        if (addr_fail !== af) report_value("addr_fail_o", 64'(af), 64'(addr_fail));
        if (flush !== (df | af)) report_value("flush_o", 64'(df | af), 64'(flush));
    endtask

    task automatic run_divide(input logic stalled, input logic sg, input logic [31:0] dvd,
                              input logic [31:0] dvs);
        logic [31:0] q_exp;
        logic [31:0] r_exp;
        logic        seen;
        int          n;
        divide_model(sg, dvd, dvs, q_exp, r_exp);
        @(posedge aclk);
        #1;
        for (int i = 0; i < 2; i++) begin
            ex2_rd[i] = 5'd0;
            wb_rd[i] = 5'd0;
            ex2_valid[i] = 1'b1;
            wb_valid[i] = 1'b1;
        end
        rj0 = 5'd1;
        rk0 = 5'd2;
        rj0_d = dvd;
        rk0_d = dvs;
        uop0 = '0;
        uop0.op_class = ex_pkg::CLS_DIV;
        uop0.sign = sg;
        uop1 = '0;
        uop1.op_class = ex_pkg::CLS_NOP;
        if (stalled) begin
            // dividend still in flight in ex2 slot 1
            ex2_rd[1] = 5'd1;
            ex2_data[1] = dvd;
            ex2_valid[1] = 1'b0;
            rj0_d = ~dvd;
            repeat (3) begin
                @(negedge aclk);
                if (fwd_stall !== 1'b1) report_value("forward_stall_o", 64'd1, 64'(fwd_stall));
                if (div_done !== 1'b0) report_value("div_done_o", 64'd0, 64'(div_done));
            end
            @(posedge aclk);
            #1;
            ex2_valid[1] = 1'b1;
        end
        @(negedge aclk);
        if (div_stall !== 1'b1) report_value("div_stall_o", 64'd1, 64'(div_stall));
        // flush only comes from a lane 0 branch, so a div never sees it
        if (flush !== 1'b0) report_value("flush_o", 64'd0, 64'(flush));
        n = 0;
        seen = 1'b0;
        while (!seen && n < 100) begin
            @(negedge aclk);
            n++;
            if (div_stall !== 1'b1) report_value("div_stall_o", 64'd1, 64'(div_stall));
            seen = div_done;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: div_done_o did not pulse within 100 cycles at %0t ns", $time);
        end else begin
            // the first sampled negedge follows the edge that accepts the start
            if (n - 1 != 33) report_value("div_done_o latency", 64'd33, 64'(n - 1));
            if (quotient !== q_exp) report_value("quotient_o", 64'(q_exp), 64'(quotient));
            if (remainder !== r_exp) report_value("remainder_o", 64'(r_exp), 64'(remainder));
        end
        @(posedge aclk);
        #1;
        uop0.op_class = ex_pkg::CLS_NOP;
        @(negedge aclk);
        if (div_done !== 1'b0) report_value("div_done_o", 64'd0, 64'(div_done));
        if (div_stall !== 1'b0) report_value("div_stall_o", 64'd0, 64'(div_stall));
    endtask

    initial begin
        void'($urandom(32'hd4d5393f));
        errors = 0;
        timeouts = 0;
        pc0 = '0;
        pc1 = '0;
        imm0 = '0;
        imm1 = '0;
        rj0 = '0;
        rk0 = '0;
        rj1 = '0;
        rk1 = '0;
        rj0_d = '0;
        rk0_d = '0;
        rj1_d = '0;
        rk1_d = '0;
        uop0 = '0;
        uop0.op_class = ex_pkg::CLS_NOP;
        uop1 = uop0;
        for (int i = 0; i < 2; i++) begin
            ex2_rd[i] = '0;
            ex2_data[i] = '0;
            ex2_valid[i] = 1'b0;
            wb_rd[i] = '0;
            wb_data[i] = '0;
            wb_valid[i] = 1'b0;
        end
        ptaken = 1'b0;
        ppc = '0;

        wait_n = 0;
        while (aresetn !== 1'b1 && wait_n < 100) begin
            @(negedge aclk);
            wait_n++;
        end
        if (aresetn !== 1'b1) begin
            timeouts++;
            $display("timeout: reset was not released within 100 cycles");
        end
        if (counter !== 64'd0) report_value("counter_o", 64'd0, counter);
        if (div_stall !== 1'b0) report_value("div_stall_o", 64'd0, 64'(div_stall));
        if (div_done !== 1'b0) report_value("div_done_o", 64'd0, 64'(div_done));

        for (int mode = 0; mode < 3; mode++) begin
            repeat (250) begin
                drive_random(mode);
                @(negedge aclk);
                check_comb();
                if (counter !== edges) report_value("counter_o", edges, counter);
            end
        end

        run_divide(1'b0, 1'b1, 32'h8000_0000, 32'hffff_ffff);
        run_divide(1'b0, 1'b1, 32'h1234_5678, 32'd0);
        run_divide(1'b0, 1'b0, 32'hffff_fff0, 32'd0);
        run_divide(1'b1, 1'b1, 32'hffff_ff85, 32'd7);
        for (int i = 0; i < 24; i++) begin
            run_divide(i % 4 == 0, 1'($urandom), $urandom,
                       ($urandom % 8 == 0) ? 32'd0 : ($urandom >> ($urandom % 28)));
        end

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ex1_stage.f
ex_pkg.sv
ex_bypass_if.sv
ex_bypass.sv
ex_alu.sv
ex_branch.sv
ex_div_ctrl.sv
ex_div_datapath.sv
ex_timer.sv
ex1_stage.sv
tb_clkgen.sv
tb_ex1_stage.sv

//--- Makefile
TB = tb_ex1_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module ex1_stage -f ex1_stage.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TB) -f ex1_stage.f
	./obj_dir/V$(TB) | tee /dev/stderr | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf obj_dir
